// ==== rv32i_types_pkg.sv ====
package rv32i_types_pkg;

    typedef logic [31:0] rv32i_word;

    // major opcodes handled by the core
    typedef enum logic [6:0] {
        opc_op     = 7'b0110011,
        opc_op_imm = 7'b0010011,
        opc_lui    = 7'b0110111,
        opc_load   = 7'b0000011,
        opc_store  = 7'b0100011,
        opc_branch = 7'b1100011
    } rv32i_opcode_t;

    // add sits at zero so an all-zero control word is harmless
    typedef enum logic [2:0] {
        alu_add    = 3'd0,
        alu_sub    = 3'd1,
        alu_and    = 3'd2,
        alu_or     = 3'd3,
        alu_xor    = 3'd4,
        alu_pass_b = 3'd5
    } alu_ops_t;

    // funct3 values
    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;
    localparam logic [2:0] F3_LW      = 3'b010;
    localparam logic [2:0] F3_SB      = 3'b000;
    localparam logic [2:0] F3_SW      = 3'b010;
    localparam logic [2:0] F3_BEQ     = 3'b000;
    localparam logic [2:0] F3_BNE     = 3'b001;

    typedef struct packed {
        alu_ops_t alu_op;
        logic     alu_src_imm;
        logic     mem_read;
        logic     mem_write;
        logic     store_byte;
        logic     load_regfile;
        logic     is_branch;
        logic     branch_ne;
        logic     wb_from_mem;
    } rv32i_control_word;

endpackage

// ==== pipe_pkg.sv ====
package pipe_pkg;

    import rv32i_types_pkg::*;

    // operand source for the execute stage
    typedef enum logic [1:0] {
        from_reg = 2'd0,
        from_mem = 2'd1,
        from_wb  = 2'd2
    } fwd_sel_t;

    typedef struct packed {
        logic      valid;
        rv32i_word pc;
        rv32i_word instr;
    } if_id_t;

    typedef struct packed {
        logic              valid;
        rv32i_control_word ctrl;
        rv32i_word         pc;
        rv32i_word         rs1_data;
        rv32i_word         rs2_data;
        rv32i_word         imm;
        logic [4:0]        rs1;
        logic [4:0]        rs2;
        logic [4:0]        rd;
    } id_ex_t;

    typedef struct packed {
        logic              valid;
        rv32i_control_word ctrl;
        rv32i_word         alu_out;
        rv32i_word         store_data;
        logic [4:0]        rd;
    } ex_mem_t;

    // only what the register write port needs
    typedef struct packed {
        logic       valid;
        logic       load_regfile;
        logic [4:0] rd;
        rv32i_word  result;
    } mem_wb_t;

endpackage

// ==== pipe_reg.sv ====
`timescale 1ns/1ps

module pipe_reg #(
    parameter type T = logic [31:0]
) (
    input  logic clk,
    input  logic arst_n_i,
    input  logic load_i,
    input  logic flush_i,
    input  T     d_i,
    output T     q_o
);

    // all-zero payload is a bubble with valid low
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            q_o <= '0;
        end else if (flush_i) begin
            q_o <= '0;
        end else if (load_i) begin
            q_o <= d_i;
        end
    end

    // hazard logic drops the load whenever it asks for a bubble
    load_flush_excl: assert property (
        @(posedge clk) disable iff (!arst_n_i) !(load_i && flush_i)
    );

endmodule

// ==== regfile.sv ====
`timescale 1ns/1ps

module regfile import rv32i_types_pkg::*; (
    input  logic       clk,
    input  logic       arst_n_i,
    input  logic       we_i,
    input  logic [4:0] waddr_i,
    input  rv32i_word  wdata_i,
    input  logic [4:0] raddr_a_i,
    input  logic [4:0] raddr_b_i,
    output rv32i_word  rdata_a_o,
    output rv32i_word  rdata_b_o
);

    // x0 has no storage
    rv32i_word regs [1:31];

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i && waddr_i != 5'd0) begin
            regs[waddr_i] <= wdata_i;
        end
    end

    // write-through, so a writeback is seen by decode in the same cycle
    function automatic rv32i_word read_port(input logic [4:0] addr);
        if (addr == 5'd0) begin
            return '0;
        end
        if (we_i && waddr_i == addr) begin
            return wdata_i;
        end
        return regs[addr];
    endfunction

    always_comb begin
        rdata_a_o = read_port(raddr_a_i);
        rdata_b_o = read_port(raddr_b_i);
    end

    // a written register reads back its new value on the next cycle
    write_read_back: assert property (
        @(posedge clk) disable iff (!arst_n_i)
        (we_i && waddr_i != 5'd0)
            |=> (raddr_a_i != $past(waddr_i) || we_i || rdata_a_o == $past(wdata_i))
    );

endmodule

// ==== decode.sv ====
`timescale 1ns/1ps

module decode import rv32i_types_pkg::*, pipe_pkg::*; (
    input  logic       clk,
    input  logic       arst_n_i,
    input  if_id_t     if_id_i,
    input  mem_wb_t    wb_i,
    output id_ex_t     id_ex_o,
    output logic [4:0] rs1_o,
    output logic [4:0] rs2_o
);

    rv32i_word         instr;
    rv32i_opcode_t     opcode;
    logic [2:0]        funct3;
    logic [6:0]        funct7;
    rv32i_word         i_imm, s_imm, b_imm, u_imm, imm;
    rv32i_word         rs1_data, rs2_data;
    rv32i_control_word ctrl;
    logic              supported, uses_rs1, uses_rs2;

    assign instr  = if_id_i.instr;
    assign opcode = rv32i_opcode_t'(instr[6:0]);
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];

    assign i_imm = {{20{instr[31]}}, instr[31:20]};
    assign s_imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign b_imm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign u_imm = {instr[31:12], 12'h000};

    always_comb begin
        ctrl      = '0;
        supported = 1'b1;
        uses_rs1  = 1'b1;
        uses_rs2  = 1'b0;
        imm       = i_imm;
        case (opcode)
            opc_op, opc_op_imm: begin
                ctrl.load_regfile = 1'b1;
                ctrl.alu_src_imm  = (opcode == opc_op_imm);
                uses_rs2          = (opcode == opc_op);
                case (funct3)
                    F3_ADD_SUB: ctrl.alu_op = (uses_rs2 && funct7[5]) ? alu_sub : alu_add;
                    F3_XOR:     ctrl.alu_op = alu_xor;
                    F3_OR:      ctrl.alu_op = alu_or;
                    F3_AND:     ctrl.alu_op = alu_and;
                    default:    supported = 1'b0;
                endcase
                // only SUB may carry a nonzero funct7
                if (uses_rs2 && funct7 != 7'b0000000
                        && !(funct3 == F3_ADD_SUB && funct7 == 7'b0100000)) begin
                    supported = 1'b0;
                end
            end
            opc_lui: begin
                uses_rs1          = 1'b0;
                imm               = u_imm;
                ctrl.alu_op       = alu_pass_b;
                ctrl.alu_src_imm  = 1'b1;
                ctrl.load_regfile = 1'b1;
            end
            opc_load: begin
                supported         = (funct3 == F3_LW);
                ctrl.alu_src_imm  = 1'b1;
                ctrl.mem_read     = 1'b1;
                ctrl.load_regfile = 1'b1;
                ctrl.wb_from_mem  = 1'b1;
            end
            opc_store: begin
                supported        = (funct3 == F3_SW) || (funct3 == F3_SB);
                uses_rs2         = 1'b1;
                imm              = s_imm;
                ctrl.alu_src_imm = 1'b1;
                ctrl.mem_write   = 1'b1;
                ctrl.store_byte  = (funct3 == F3_SB);
            end
            opc_branch: begin
                supported      = (funct3 == F3_BEQ) || (funct3 == F3_BNE);
                uses_rs2       = 1'b1;
                imm            = b_imm;
                ctrl.is_branch = 1'b1;
                ctrl.branch_ne = (funct3 == F3_BNE);
            end
            default: supported = 1'b0;
        endcase
        // anything else leaves as a bubble
        if (!supported || !if_id_i.valid) begin
            ctrl     = '0;
            uses_rs1 = 1'b0;
            uses_rs2 = 1'b0;
        end
    end

    // unused source fields read as x0 so they never trigger hazards
    assign rs1_o = uses_rs1 ? instr[19:15] : 5'd0;
    assign rs2_o = uses_rs2 ? instr[24:20] : 5'd0;

    regfile u_regfile (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .we_i     (wb_i.valid && wb_i.load_regfile),
        .waddr_i  (wb_i.rd),
        .wdata_i  (wb_i.result),
        .raddr_a_i(rs1_o),
        .raddr_b_i(rs2_o),
        .rdata_a_o(rs1_data),
        .rdata_b_o(rs2_data)
    );

    always_comb begin
        id_ex_o.valid    = if_id_i.valid && supported;
        id_ex_o.ctrl     = ctrl;
        id_ex_o.pc       = if_id_i.pc;
        id_ex_o.rs1_data = rs1_data;
        id_ex_o.rs2_data = rs2_data;
        id_ex_o.imm      = imm;
        id_ex_o.rs1      = rs1_o;
        id_ex_o.rs2      = rs2_o;
        id_ex_o.rd       = ctrl.load_regfile ? instr[11:7] : 5'd0;
    end

endmodule

// ==== execute.sv ====
`timescale 1ns/1ps

module execute import rv32i_types_pkg::*, pipe_pkg::*; (
    input  id_ex_t    id_ex_i,
    input  fwd_sel_t  fwd_a_i,
    input  fwd_sel_t  fwd_b_i,
    input  rv32i_word mem_fwd_i,
    input  rv32i_word wb_fwd_i,
    output ex_mem_t   ex_mem_o,
    output logic      br_taken_o,
    output rv32i_word br_target_o
);

    rv32i_word rs1_val, rs2_val, op_b, alu_out;

    function automatic rv32i_word fwd_mux(
        input fwd_sel_t  sel,
        input rv32i_word reg_val,
        input rv32i_word mem_val,
        input rv32i_word wb_val
    );
        case (sel)
            from_mem: return mem_val;
            from_wb:  return wb_val;
            default:  return reg_val;
        endcase
    endfunction

    assign rs1_val = fwd_mux(fwd_a_i, id_ex_i.rs1_data, mem_fwd_i, wb_fwd_i);
    assign rs2_val = fwd_mux(fwd_b_i, id_ex_i.rs2_data, mem_fwd_i, wb_fwd_i);
    assign op_b    = id_ex_i.ctrl.alu_src_imm ? id_ex_i.imm : rs2_val;

    always_comb begin
        case (id_ex_i.ctrl.alu_op)
            alu_sub:    alu_out = rs1_val - op_b;
            alu_and:    alu_out = rs1_val & op_b;
            alu_or:     alu_out = rs1_val | op_b;
            alu_xor:    alu_out = rs1_val ^ op_b;
            alu_pass_b: alu_out = op_b;
            default:    alu_out = rs1_val + op_b;
        endcase
    end

    // branches resolve here, beq/bne only
    assign br_taken_o = id_ex_i.valid && id_ex_i.ctrl.is_branch
                        && ((rs1_val == rs2_val) != id_ex_i.ctrl.branch_ne);
    assign br_target_o = id_ex_i.pc + id_ex_i.imm;

    always_comb begin
        ex_mem_o.valid      = id_ex_i.valid;
        ex_mem_o.ctrl       = id_ex_i.ctrl;
        ex_mem_o.alu_out    = alu_out;
        ex_mem_o.store_data = rs2_val;
        ex_mem_o.rd         = id_ex_i.rd;
    end

endmodule

// ==== hazard_unit.sv ====
`timescale 1ns/1ps

module hazard_unit import pipe_pkg::*; (
    input  logic       [4:0] id_rs1_i,
    input  logic       [4:0] id_rs2_i,
    input  id_ex_t           id_ex_i,
    input  ex_mem_t          ex_mem_i,
    input  mem_wb_t          mem_wb_i,
    input  logic             br_taken_i,
    input  logic             i_mem_read_i,
    input  logic             i_mem_resp_i,
    input  logic             d_mem_req_i,
    input  logic             d_mem_resp_i,
    output fwd_sel_t         fwd_a_o,
    output fwd_sel_t         fwd_b_o,
    output logic             stall_mem_o,
    output logic             stall_lu_o,
    output logic             flush_br_o
);

    logic load_use;

    // youngest producer wins, x0 never forwards
    function automatic fwd_sel_t pick_src(input logic [4:0] rs);
        if (rs != 5'd0 && ex_mem_i.valid && ex_mem_i.ctrl.load_regfile && ex_mem_i.rd == rs) begin
            return from_mem;
        end
        if (rs != 5'd0 && mem_wb_i.valid && mem_wb_i.load_regfile && mem_wb_i.rd == rs) begin
            return from_wb;
        end
        return from_reg;
    endfunction

    always_comb begin
        fwd_a_o = pick_src(id_ex_i.rs1);
        fwd_b_o = pick_src(id_ex_i.rs2);
    end

    assign load_use = id_ex_i.valid && id_ex_i.ctrl.mem_read && id_ex_i.rd != 5'd0
                      && (id_ex_i.rd == id_rs1_i || id_ex_i.rd == id_rs2_i);

    // an outstanding memory request freezes everything
    assign stall_mem_o = (i_mem_read_i && !i_mem_resp_i) || (d_mem_req_i && !d_mem_resp_i);
    assign stall_lu_o  = load_use && !stall_mem_o;
    assign flush_br_o  = br_taken_i && !stall_mem_o;

    br_lu_excl: assert final (!(flush_br_o && stall_lu_o)
                              && (!flush_br_o || (id_ex_i.valid && id_ex_i.ctrl.is_branch)));

endmodule

// ==== datapath.sv ====
`timescale 1ns/1ps

module datapath import rv32i_types_pkg::*, pipe_pkg::*; #(
    parameter rv32i_word RESET_PC = 32'h0000_0000
) (
    input  logic       clk,
    input  logic       arst_n_i,
    input  rv32i_word  i_mem_rdata_i,
    input  logic       i_mem_resp_i,
    output rv32i_word  i_mem_address_o,
    output logic       i_mem_read_o,
    input  rv32i_word  d_mem_rdata_i,
    input  logic       d_mem_resp_i,
    output rv32i_word  d_mem_address_o,
    output logic       d_mem_read_o,
    output logic       d_mem_write_o,
    output rv32i_word  d_mem_wdata_o,
    output logic [3:0] d_mbe_o
);

    rv32i_word  pc, br_target, i_buf, d_buf, load_data;
    logic       i_done, d_done, d_req;
    logic       stall_mem, stall_lu, flush_br, br_taken, front_load;
    logic [4:0] id_rs1, id_rs2;
    fwd_sel_t   fwd_a, fwd_b;
    if_id_t     if_d, if_q;
    id_ex_t     id_d, id_q;
    ex_mem_t    ex_d, ex_q;
    mem_wb_t    wb_d, wb_q;

    // pc and instruction fetch
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            pc <= RESET_PC;
        end else if (flush_br) begin
            pc <= br_target;
        end else if (!stall_mem && !stall_lu) begin
            pc <= pc + 32'd4;
        end
    end

    // a port that already responded while the other side still stalls
    // keeps its result here and drops its request until the pipe advances
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            i_done <= 1'b0;
            d_done <= 1'b0;
        end else if (!stall_mem) begin
            i_done <= 1'b0;
            d_done <= 1'b0;
        end else begin
            i_done <= i_done || (i_mem_read_o && i_mem_resp_i);
            d_done <= d_done || (d_req && d_mem_resp_i);
        end
    end

    always_ff @(posedge clk) begin
        if (i_mem_read_o && i_mem_resp_i) begin
            i_buf <= i_mem_rdata_i;
        end
        if (d_req && d_mem_resp_i) begin
            d_buf <= d_mem_rdata_i;
        end
    end

    assign i_mem_address_o = pc;
    assign i_mem_read_o    = !i_done;
    assign if_d = '{valid: 1'b1, pc: pc, instr: (i_done ? i_buf : i_mem_rdata_i)};

    // front stages hold on load-use and take a bubble on a taken branch
    assign front_load = !stall_mem && !stall_lu && !flush_br;

    pipe_reg #(.T(if_id_t)) u_if_id (
        .clk(clk), .arst_n_i(arst_n_i),
        .load_i(front_load), .flush_i(flush_br), .d_i(if_d), .q_o(if_q)
    );

    decode u_decode (
        .clk(clk), .arst_n_i(arst_n_i),
        .if_id_i(if_q), .wb_i(wb_q), .id_ex_o(id_d), .rs1_o(id_rs1), .rs2_o(id_rs2)
    );

    pipe_reg #(.T(id_ex_t)) u_id_ex (
        .clk(clk), .arst_n_i(arst_n_i),
        .load_i(front_load), .flush_i(flush_br || stall_lu), .d_i(id_d), .q_o(id_q)
    );

    execute u_execute (
        .id_ex_i(id_q), .fwd_a_i(fwd_a), .fwd_b_i(fwd_b),
        .mem_fwd_i(ex_q.alu_out), .wb_fwd_i(wb_q.result),
        .ex_mem_o(ex_d), .br_taken_o(br_taken), .br_target_o(br_target)
    );

    pipe_reg #(.T(ex_mem_t)) u_ex_mem (
        .clk(clk), .arst_n_i(arst_n_i),
        .load_i(!stall_mem), .flush_i(1'b0), .d_i(ex_d), .q_o(ex_q)
    );

    // memory stage, word aligned address
    assign d_mem_read_o    = ex_q.valid && ex_q.ctrl.mem_read && !d_done;
    assign d_mem_write_o   = ex_q.valid && ex_q.ctrl.mem_write && !d_done;
    assign d_req           = d_mem_read_o || d_mem_write_o;
    assign d_mem_address_o = {ex_q.alu_out[31:2], 2'b00};
    assign d_mbe_o = ex_q.ctrl.store_byte ? (4'b0001 << ex_q.alu_out[1:0]) : 4'b1111;
    assign d_mem_wdata_o = ex_q.ctrl.store_byte ? {4{ex_q.store_data[7:0]}} : ex_q.store_data;

    assign load_data = d_done ? d_buf : d_mem_rdata_i;
    assign wb_d = '{valid: ex_q.valid, load_regfile: ex_q.ctrl.load_regfile, rd: ex_q.rd,
                    result: (ex_q.ctrl.wb_from_mem ? load_data : ex_q.alu_out)};

    pipe_reg #(.T(mem_wb_t)) u_mem_wb (
        .clk(clk), .arst_n_i(arst_n_i),
        .load_i(!stall_mem), .flush_i(1'b0), .d_i(wb_d), .q_o(wb_q)
    );

    hazard_unit u_hazard (
        .id_rs1_i(id_rs1), .id_rs2_i(id_rs2),
        .id_ex_i(id_q), .ex_mem_i(ex_q), .mem_wb_i(wb_q),
        .br_taken_i(br_taken),
        .i_mem_read_i(i_mem_read_o), .i_mem_resp_i(i_mem_resp_i),
        .d_mem_req_i(d_req), .d_mem_resp_i(d_mem_resp_i),
        .fwd_a_o(fwd_a), .fwd_b_o(fwd_b),
        .stall_mem_o(stall_mem), .stall_lu_o(stall_lu), .flush_br_o(flush_br)
    );

    // pending data request holds its fields until the response edge
    d_req_hold: assert property (
        @(posedge clk) disable iff (!arst_n_i)
        (d_req && !d_mem_resp_i) |=> (d_req && $stable(d_mem_write_o) && $stable(d_mem_address_o)
                                      && $stable(d_mem_wdata_o) && $stable(d_mbe_o))
    );

endmodule

// ==== tb_datapath.sv ====
`timescale 1ns/1ps

module tb_datapath;

    localparam int BODY_LEN  = 200;
    localparam int PROG_MAX  = 256;
    localparam int MEM_WORDS = 512;

    // opcodes of the generated program, arithmetic groups kept contiguous
    localparam int OP_ADD = 0, OP_SUB = 1, OP_AND = 2, OP_OR = 3, OP_XOR = 4;
    localparam int OP_ADDI = 5, OP_ANDI = 6, OP_ORI = 7, OP_XORI = 8;
    localparam int OP_LUI = 9, OP_LW = 10, OP_SW = 11, OP_SB = 12, OP_BEQ = 13, OP_BNE = 14;

    logic        clk;
    logic        arst_n_i;
    logic [31:0] i_mem_rdata_i, i_mem_address_o, d_mem_rdata_i, d_mem_address_o, d_mem_wdata_o;
    logic        i_mem_resp_i, i_mem_read_o, d_mem_resp_i, d_mem_read_o, d_mem_write_o;
    logic [3:0]  d_mbe_o;

    integer      seed;
    int          prog_len, n_exp, st_seen, k, cycles;
    logic [31:0] loop_pc;
    int          p_op  [0:PROG_MAX-1];
    logic [4:0]  p_rd  [0:PROG_MAX-1];
    logic [4:0]  p_rs1 [0:PROG_MAX-1];
    logic [4:0]  p_rs2 [0:PROG_MAX-1];
    logic [31:0] p_imm [0:PROG_MAX-1];
    logic [31:0] imem  [0:PROG_MAX-1];
    logic [31:0] dmem  [0:MEM_WORDS-1];
    logic [31:0] exp_addr [0:MEM_WORDS-1];
    logic [31:0] exp_data [0:MEM_WORDS-1];
    logic [3:0]  exp_mbe  [0:MEM_WORDS-1];

    // memory model state
    logic        i_busy, d_busy, d_write;
    int          i_cnt, d_cnt;
    logic [31:0] i_addr, d_addr, d_wdata;
    logic [3:0]  d_mbe;

    datapath #(.RESET_PC(32'h0000_0000)) uut (.*);

    always #20 clk = ~clk;

    task automatic fail_run(input string why);
        $display("Error at %0t: %s", $time, why);
        $display("Verification failed");
        $fatal(1);
    endtask

    task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("Error at %0t: %s is %h, expected %h", $time, name, got, exp);
            $display("Verification failed");
            $fatal(1);
        end
    endtask

    function automatic int rand_below(input int n);
        return ($random(seed) & 32'h7fff_ffff) % n;
    endfunction

    // mostly x1..x7 so that dependencies stay close together
    function automatic logic [4:0] pick_reg();
        return (rand_below(4) == 0) ? 5'(rand_below(32)) : 5'(rand_below(8));
    endfunction

    function automatic logic [31:0] mem_fill(input int idx);
        return idx * 32'h9e37_79b1 + 32'h3c6e_f372;
    endfunction

    function automatic logic [31:0] merge_bytes(input logic [31:0] old, input logic [31:0] data,
                                                input logic [3:0] be);
        logic [31:0] res;
        int          b;
        res = old;
        for (b = 0; b < 4; b++) begin
            if (be[b]) res[8*b +: 8] = data[8*b +: 8];
        end
        return res;
    endfunction

    function automatic logic [31:0] encode(input int op, input logic [4:0] rd, input logic [4:0] rs1,
                                           input logic [4:0] rs2, input logic [31:0] imm);
        case (op)
            OP_ADD:  return {7'h00, rs2, rs1, 3'b000, rd, 7'h33};
            OP_SUB:  return {7'h20, rs2, rs1, 3'b000, rd, 7'h33};
            OP_AND:  return {7'h00, rs2, rs1, 3'b111, rd, 7'h33};
            OP_OR:   return {7'h00, rs2, rs1, 3'b110, rd, 7'h33};
            OP_XOR:  return {7'h00, rs2, rs1, 3'b100, rd, 7'h33};
            OP_ADDI: return {imm[11:0], rs1, 3'b000, rd, 7'h13};
            OP_ANDI: return {imm[11:0], rs1, 3'b111, rd, 7'h13};
            OP_ORI:  return {imm[11:0], rs1, 3'b110, rd, 7'h13};
            OP_XORI: return {imm[11:0], rs1, 3'b100, rd, 7'h13};
            OP_LUI:  return {imm[31:12], rd, 7'h37};
            OP_LW:   return {imm[11:0], rs1, 3'b010, rd, 7'h03};
            OP_SW:   return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'h23};
            OP_SB:   return {imm[11:5], rs2, rs1, 3'b000, imm[4:0], 7'h23};
            OP_BEQ:  return {imm[12], imm[10:5], rs2, rs1, 3'b000, imm[4:1], imm[11], 7'h63};
            OP_BNE:  return {imm[12], imm[10:5], rs2, rs1, 3'b001, imm[4:1], imm[11], 7'h63};
            default: return 32'h0000_0013;
        endcase
    endfunction

    task automatic add_instr(input int op, input logic [4:0] rd, input logic [4:0] rs1,
                             input logic [4:0] rs2, input logic [31:0] imm);
        p_op[prog_len]  = op;
        p_rd[prog_len]  = rd;
        p_rs1[prog_len] = rs1;
        p_rs2[prog_len] = rs2;
        p_imm[prog_len] = imm;
        imem[prog_len]  = encode(op, rd, rs1, rs2, imm);
        prog_len++;
    endtask

    task automatic build_program();
        int          i, kind;
        logic [4:0]  rd, rs1, rs2;
        logic [31:0] imm;
        prog_len = 0;
        for (i = 0; i < BODY_LEN; i++) begin
            kind = rand_below(16);
            rd   = pick_reg();
            rs1  = pick_reg();
            rs2  = pick_reg();
            imm  = $random(seed);
            imm  = {{20{imm[11]}}, imm[11:0]};
            // no branch may jump into the register dump
            if (kind >= 14 && i >= BODY_LEN - 4) kind = 0;
            if (kind <= 3) add_instr(OP_ADD + rand_below(5), rd, rs1, rs2, 32'h0);
            else if (kind <= 5) add_instr(OP_ADDI + rand_below(4), rd, rs1, 5'd0, imm);
            else if (kind == 6) add_instr(OP_LUI, rd, 5'd0, 5'd0, $random(seed) & 32'hffff_f000);
            else if (kind <= 8) add_instr(OP_LW, rd, 5'd0, 5'd0, 4 * rand_below(64));
            else if (kind <= 11) add_instr(OP_SW, 5'd0, 5'd0, rs2, 4 * rand_below(64));
            else if (kind <= 13) add_instr(OP_SB, 5'd0, 5'd0, rs2, rand_below(256));
            else begin
                if (rand_below(2) == 0) rs2 = rs1;
                add_instr(kind == 14 ? OP_BEQ : OP_BNE, 5'd0, rs1, rs2, 4 * (2 + rand_below(3)));
            end
        end
        // register dump, x0 included
        for (i = 0; i < 32; i++) add_instr(OP_SW, 5'd0, 5'd0, 5'(i), 32'h400 + 4 * i);
        add_instr(OP_BEQ, 5'd0, 5'd0, 5'd0, 32'h0);
        loop_pc = 4 * (prog_len - 1);
    endtask

    // reference ISS, records every store in program order
    task automatic run_iss();
        logic [31:0] x   [0:31];
        logic [31:0] mem [0:MEM_WORDS-1];
        logic [31:0] a, b, addr;
        int          pc, r;
        for (r = 0; r < 32; r++) x[r] = '0;
        for (r = 0; r < MEM_WORDS; r++) mem[r] = mem_fill(r);
        pc    = 0;
        n_exp = 0;
        while (pc != prog_len - 1) begin
            a    = x[p_rs1[pc]];
            b    = x[p_rs2[pc]];
            addr = a + p_imm[pc];
            case (p_op[pc])
                OP_ADD:  x[p_rd[pc]] = a + b;
                OP_SUB:  x[p_rd[pc]] = a - b;
                OP_AND:  x[p_rd[pc]] = a & b;
                OP_OR:   x[p_rd[pc]] = a | b;
                OP_XOR:  x[p_rd[pc]] = a ^ b;
                OP_ADDI: x[p_rd[pc]] = a + p_imm[pc];
                OP_ANDI: x[p_rd[pc]] = a & p_imm[pc];
                OP_ORI:  x[p_rd[pc]] = a | p_imm[pc];
                OP_XORI: x[p_rd[pc]] = a ^ p_imm[pc];
                OP_LUI:  x[p_rd[pc]] = p_imm[pc];
                OP_LW:   x[p_rd[pc]] = mem[addr[10:2]];
                default: ;
            endcase
            if (p_op[pc] == OP_SW || p_op[pc] == OP_SB) begin
                exp_addr[n_exp] = {addr[31:2], 2'b00};
                exp_mbe[n_exp]  = (p_op[pc] == OP_SB) ? (4'b0001 << addr[1:0]) : 4'b1111;
                exp_data[n_exp] = (p_op[pc] == OP_SB) ? {4{b[7:0]}} : b;
                mem[addr[10:2]] = merge_bytes(mem[addr[10:2]], exp_data[n_exp], exp_mbe[n_exp]);
                n_exp++;
            end
            x[0] = '0;
            if ((p_op[pc] == OP_BEQ && a == b) || (p_op[pc] == OP_BNE && a != b)) begin
                pc = pc + ($signed(p_imm[pc]) >>> 2);
            end else begin
                pc = pc + 1;
            end
        end
    endtask

    function automatic logic [31:0] fetch_word(input logic [31:0] addr);
        if (addr[1:0] == 2'b00 && (addr >> 2) < prog_len) return imem[addr >> 2];
        return 32'h0000_0013;
    endfunction

    // both memories, each response 0 to 2 cycles after the request is seen
    always @(posedge clk) begin
        if (!arst_n_i) begin
            i_mem_resp_i <= 1'b0;
            d_mem_resp_i <= 1'b0;
            i_busy = 1'b0;
            d_busy = 1'b0;
        end else begin
            if (i_mem_resp_i) begin
                i_mem_resp_i <= 1'b0;
                i_busy = 1'b0;
            end else begin
                if (!i_busy && i_mem_read_o) begin
                    i_busy = 1'b1;
                    i_addr = i_mem_address_o;
                    i_cnt  = rand_below(3);
                end
                if (i_busy && i_cnt == 0) begin
                    i_mem_resp_i  <= 1'b1;
                    i_mem_rdata_i <= fetch_word(i_addr);
                end else if (i_busy) begin
                    i_cnt = i_cnt - 1;
                end
            end
            if (d_mem_resp_i) begin
                // request fields must not have moved since acceptance
                check_val("d_mem_write_o", d_mem_write_o, d_write);
                check_val("d_mem_address_o", d_mem_address_o, d_addr);
                check_val("d_mem_wdata_o", d_mem_wdata_o, d_wdata);
                check_val("d_mbe_o", d_mbe_o, d_mbe);
                if (d_write && st_seen >= n_exp) begin
                    fail_run("the DUT made a store that the reference ISS did not make");
                end else if (d_write) begin
                    check_val("d_mem_address_o", d_mem_address_o, exp_addr[st_seen]);
                    check_val("d_mbe_o", d_mbe_o, exp_mbe[st_seen]);
                    check_val("d_mem_wdata_o", d_mem_wdata_o, exp_data[st_seen]);
                    dmem[d_addr[10:2]] = merge_bytes(dmem[d_addr[10:2]], d_wdata, d_mbe);
                    st_seen <= st_seen + 1;
                end
                d_mem_resp_i <= 1'b0;
                d_busy = 1'b0;
            end else begin
                if (!d_busy && (d_mem_read_o || d_mem_write_o)) begin
                    d_busy  = 1'b1;
                    d_write = d_mem_write_o;
                    d_addr  = d_mem_address_o;
                    d_wdata = d_mem_wdata_o;
                    d_mbe   = d_mbe_o;
                    d_cnt   = rand_below(3);
                end
                if (d_busy && d_cnt == 0) begin
                    d_mem_resp_i  <= 1'b1;
                    d_mem_rdata_i <= dmem[d_addr[10:2]];
                end else if (d_busy) begin
                    d_cnt = d_cnt - 1;
                end
            end
        end
    end

    initial begin
        clk           = 1'b0;
        arst_n_i      = 1'b0;
        i_mem_rdata_i = '0;
        i_mem_resp_i  = 1'b0;
        d_mem_rdata_i = '0;
        d_mem_resp_i  = 1'b0;
        st_seen       = 0;
        seed          = 32'ha517;
        build_program();
        run_iss();
        for (k = 0; k < MEM_WORDS; k++) dmem[k] = mem_fill(k);

        repeat (4) @(posedge clk);
        @(negedge clk);
        check_val("i_mem_address_o", i_mem_address_o, 32'h0000_0000);
        check_val("i_mem_read_o", i_mem_read_o, 1'b1);
        check_val("d_mem_read_o", d_mem_read_o, 1'b0);
        check_val("d_mem_write_o", d_mem_write_o, 1'b0);
        repeat (4) @(posedge clk);
        arst_n_i <= 1'b1;

        cycles = 0;
        while (!(i_mem_read_o && i_mem_resp_i)) begin
            @(posedge clk);
            cycles++;
            if (cycles > 20) fail_run("no instruction fetch completed after reset release");
        end

        for (k = 0; k < n_exp; k++) begin
            cycles = 0;
            while (st_seen <= k) begin
                @(posedge clk);
                cycles++;
                if (cycles > 200) fail_run($sformatf("store %0d never completed", k));
            end
        end

        cycles = 0;
        while (i_mem_address_o !== loop_pc) begin
            @(posedge clk);
            cycles++;
            if (cycles > 5000) fail_run("the PC never reached the final loop");
        end
        // a late extra store would still show up here
        repeat (20) @(posedge clk);
        $display("Verification passed");
        $finish;
    end

endmodule

// ==== files.f ====
rv32i_types_pkg.sv
pipe_pkg.sv
pipe_reg.sv
regfile.sv
decode.sv
execute.sv
hazard_unit.sv
datapath.sv
tb_datapath.sv

// ==== Bender.yml ====
package:
  name: rv32i_pipe

sources:
  - rv32i_types_pkg.sv
  - pipe_pkg.sv
  - pipe_reg.sv
  - regfile.sv
  - decode.sv
  - execute.sv
  - hazard_unit.sv
  - datapath.sv
  - target: test
    files:
      - tb_datapath.sv
